//--- rtl/clic_pkg.sv
/*
 * Shared definitions for the per-hart interrupt controller subsystem:
 * bus widths and types, the slice address map with register offsets,
 * CLINT source bit positions and the decode error read value.
 */

package clic_pkg;

  // ------------------------------------------------------------------------
  // widths and types
  // ------------------------------------------------------------------------
  localparam int unsigned REG_AW    = 32;
  localparam int unsigned REG_DW    = 32;
  localparam int unsigned NUM_SRC   = 16;
  localparam int unsigned SRC_IDX_W = 4;

  typedef logic [REG_AW-1:0]    reg_addr_t;
  typedef logic [REG_DW-1:0]    reg_data_t;
  typedef logic [NUM_SRC-1:0]   src_vec_t;
  typedef logic [SRC_IDX_W-1:0] src_id_t;

  // ------------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------------
  localparam reg_addr_t CLIC_BASE   = 32'h5000_0000;
  localparam reg_addr_t HART_STRIDE = 32'h0004_0000;

  // offset bits decoded inside one hart window
  localparam int unsigned OFF_W = $clog2(HART_STRIDE);

  localparam reg_addr_t OFF_ENABLE  = 32'h0;
  localparam reg_addr_t OFF_SWPEND  = 32'h4;
  localparam reg_addr_t OFF_PENDING = 32'h8;
  localparam reg_addr_t OFF_CLAIM   = 32'hC;

  // standard CLINT positions in the source vector
  localparam int unsigned SRC_MSIP = 3;
  localparam int unsigned SRC_MTIP = 7;
  localparam int unsigned SRC_SEIP = 9;
  localparam int unsigned SRC_MEIP = 11;

  // read value for addresses outside every hart window
  localparam reg_data_t ERR_VAL = 32'hBADCAB1E;

endpackage

//--- rtl/reg_addr_demux.sv
/*
 * Register bus address decoder.
 * Matches the address against one window per hart, strobes the matching
 * slice and registers the response select and valid pulse. Addresses that
 * hit no window select the error target, index NUM_HARTS.
 */

`timescale 1ns/100ps

module reg_addr_demux #(
  parameter int unsigned NUM_HARTS = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  clic_pkg::reg_addr_t                addr_i,
  output logic [NUM_HARTS-1:0]               slice_req_o,
  output logic [$clog2(NUM_HARTS + 1)-1:0]   rsp_sel_o,
  output logic                               rsp_valid_o
);

  import clic_pkg::*;

  localparam int unsigned SEL_W = $clog2(NUM_HARTS + 1);

  logic [NUM_HARTS-1:0] hit;
  logic [SEL_W-1:0]     sel_d;
  logic [SEL_W-1:0]     sel_q;
  logic                 valid_q;

  // one address window per hart
  for (genvar h = 0; h < NUM_HARTS; h++) begin : gen_win
    localparam reg_addr_t WIN_LO = CLIC_BASE + reg_addr_t'(h) * HART_STRIDE;

    assign hit[h] = (addr_i >= WIN_LO) && (addr_i < WIN_LO + HART_STRIDE);

    // a strobed slice must be the one answering next cycle
    a_sel_follows_strobe : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      slice_req_o[h] |=> (rsp_valid_o && (rsp_sel_o == SEL_W'(h)))
    );
  end

  // default to the error target
  always_comb begin
    sel_d = SEL_W'(NUM_HARTS);
    for (int unsigned h = 0; h < NUM_HARTS; h++) begin
      if (hit[h]) begin
        sel_d = SEL_W'(h);
      end
    end
  end

  assign slice_req_o = req_i ? hit : '0;

  // ------------------------------------------------------------------------
  // response path, one cycle behind the request
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
      if (req_i) begin
        sel_q <= sel_d;
      end
    end
  end

  assign rsp_sel_o   = sel_q;
  assign rsp_valid_o = valid_q;

  a_req_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(slice_req_o)
  );

endmodule

//--- rtl/hart_irq_ctrl.sv
/*
 * Interrupt controller for one hart.
 * Captures the level sources, holds the enable and software-pending
 * registers, selects the highest enabled pending source and answers
 * register reads one cycle after the request.
 */

`timescale 1ns/100ps

module hart_irq_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [clic_pkg::OFF_W-1:0]    offset_i,
  input  clic_pkg::reg_data_t           wdata_i,
  input  logic                          timer_irq_i,
  input  logic                          meip_i,
  input  logic                          seip_i,
  output clic_pkg::reg_data_t           rdata_o,
  output logic                          irq_valid_o,
  output clic_pkg::src_id_t             irq_id_o
);

  import clic_pkg::*;

  logic      mtip_q;
  logic      meip_q;
  logic      seip_q;
  logic      swpend_q;
  src_vec_t  enable_q;
  src_vec_t  pending;
  src_vec_t  active;
  src_id_t   id_d;
  reg_data_t rd_val;
  reg_data_t rdata_q;

  // ------------------------------------------------------------------------
  // source capture
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtip_q <= 1'b0;
      meip_q <= 1'b0;
      seip_q <= 1'b0;
    end else begin
      mtip_q <= timer_irq_i;
      meip_q <= meip_i;
      seip_q <= seip_i;
    end
  end

  always_comb begin
    pending           = '0;
    pending[SRC_MSIP] = swpend_q;
    pending[SRC_MTIP] = mtip_q;
    pending[SRC_SEIP] = seip_q;
    pending[SRC_MEIP] = meip_q;
  end

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= '0;
      swpend_q <= 1'b0;
    end else if (req_i && we_i) begin
      if (offset_i == OFF_W'(OFF_ENABLE)) begin
        enable_q <= wdata_i[NUM_SRC-1:0];
      end
      if (offset_i == OFF_W'(OFF_SWPEND)) begin
        swpend_q <= wdata_i[0];
      end
    end
  end

  // highest index wins
  assign active = pending & enable_q;

  always_comb begin
    id_d = '0;
    for (int unsigned i = 0; i < NUM_SRC; i++) begin
      if (active[i]) begin
        id_d = src_id_t'(i);
      end
    end
  end

  assign irq_valid_o = |active;
  assign irq_id_o    = id_d;

  // ------------------------------------------------------------------------
  // read data
  // ------------------------------------------------------------------------
  always_comb begin
    case (offset_i)
      OFF_W'(OFF_ENABLE):  rd_val = reg_data_t'(enable_q);
      OFF_W'(OFF_SWPEND):  rd_val = reg_data_t'(swpend_q);
      OFF_W'(OFF_PENDING): rd_val = reg_data_t'(pending);
      OFF_W'(OFF_CLAIM):   rd_val = {irq_valid_o, {(REG_DW - 1 - SRC_IDX_W){1'b0}}, id_d};
      default:             rd_val = '0;
    endcase
  end

  // writes answer with zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= we_i ? '0 : rd_val;
    end
  end

  assign rdata_o = rdata_q;

  a_claim_is_active : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_valid_o |-> (pending[irq_id_o] && enable_q[irq_id_o])
  );

endmodule

//--- rtl/reg_rsp_mux.sv
/*
 * Register bus response multiplexer.
 * Returns the read data of the slice named by the registered select, or
 * the fixed error value with the error flag for the error target.
 */

`timescale 1ns/100ps

module reg_rsp_mux #(
  parameter int unsigned NUM_HARTS = 4
) (
  input  logic [$clog2(NUM_HARTS + 1)-1:0]       rsp_sel_i,
  input  logic                                   rsp_valid_i,
  input  clic_pkg::reg_data_t [NUM_HARTS-1:0]    slice_rdata_i,
  output logic                                   rsp_valid_o,
  output clic_pkg::reg_data_t                    rdata_o,
  output logic                                   rsp_err_o
);

  import clic_pkg::*;

  localparam int unsigned SEL_W = $clog2(NUM_HARTS + 1);

  logic      is_err;
  reg_data_t sel_data;

  // anything past the last hart is the error target
  assign is_err = (rsp_sel_i >= SEL_W'(NUM_HARTS));

  always_comb begin
    if (is_err) begin
      sel_data = ERR_VAL;
    end else begin
      sel_data = slice_rdata_i[rsp_sel_i];
    end
  end

  // ------------------------------------------------------------------------
  // outputs, quiet outside a response cycle
  // ------------------------------------------------------------------------
  assign rsp_valid_o = rsp_valid_i;
  assign rdata_o     = rsp_valid_i ? sel_data : '0;
  assign rsp_err_o   = rsp_valid_i && is_err;

endmodule

//--- rtl/debug_req_gate.sv
/*
 * Debug request gate.
 * Holds all per-hart debug requests low for DEL_CYCLES cycles after reset,
 * then passes them while debug is enabled.
 */

`timescale 1ns/100ps

module debug_req_gate #(
  parameter int unsigned NUM_HARTS  = 4,
  parameter int unsigned DEL_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 debug_enable_i,
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  localparam int unsigned CNT_W = (DEL_CYCLES > 0) ? $clog2(DEL_CYCLES + 1) : 1;

  logic [CNT_W-1:0] cnt_q;
  logic             hold;

  // post-reset delay counter that stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(DEL_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  assign hold        = (cnt_q != '0) || !debug_enable_i;
  assign debug_req_o = hold ? '0 : debug_req_i;

  a_quiet_while_counting : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> (debug_req_o == '0)
  );

endmodule

//--- rtl/irq_subsystem_top.sv
/*
 * Interrupt subsystem top level.
 * Connects the address decoder, one interrupt controller slice per hart,
 * the response multiplexer and the debug request gate.
 */

`timescale 1ns/100ps

module irq_subsystem_top #(
  parameter int unsigned NUM_HARTS  = 4,
  parameter int unsigned DEL_CYCLES = 500
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // register bus
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  clic_pkg::reg_addr_t                 reg_addr_i,
  input  clic_pkg::reg_data_t                 reg_wdata_i,
  output logic                                reg_rsp_valid_o,
  output clic_pkg::reg_data_t                 reg_rdata_o,
  output logic                                reg_rsp_err_o,
  // interrupt levels and core notification
  input  logic [NUM_HARTS-1:0]                timer_irq_i,
  input  logic [NUM_HARTS-1:0]                meip_i,
  input  logic [NUM_HARTS-1:0]                seip_i,
  output logic [NUM_HARTS-1:0]                irq_valid_o,
  output clic_pkg::src_id_t [NUM_HARTS-1:0]   irq_id_o,
  // debug
  input  logic                                debug_enable_i,
  input  logic [NUM_HARTS-1:0]                debug_req_i,
  output logic [NUM_HARTS-1:0]                debug_req_o
);

  import clic_pkg::*;

  localparam int unsigned SEL_W = $clog2(NUM_HARTS + 1);

  logic [NUM_HARTS-1:0]      slice_req;
  logic [SEL_W-1:0]          rsp_sel;
  logic                      rsp_valid;
  reg_data_t [NUM_HARTS-1:0] slice_rdata;

  // ------------------------------------------------------------------------
  // register bus
  // ------------------------------------------------------------------------
  reg_addr_demux #(
    .NUM_HARTS   ( NUM_HARTS )
  ) i_reg_addr_demux (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .req_i       ( reg_req_i  ),
    .addr_i      ( reg_addr_i ),
    .slice_req_o ( slice_req  ),
    .rsp_sel_o   ( rsp_sel    ),
    .rsp_valid_o ( rsp_valid  )
  );

  for (genvar h = 0; h < NUM_HARTS; h++) begin : gen_hart
    hart_irq_ctrl i_hart_irq_ctrl (
      .clk_i       ( clk_i                  ),
      .rst_ni      ( rst_ni                 ),
      .req_i       ( slice_req[h]           ),
      .we_i        ( reg_we_i               ),
      .offset_i    ( reg_addr_i[OFF_W-1:0]  ),
      .wdata_i     ( reg_wdata_i            ),
      .timer_irq_i ( timer_irq_i[h]         ),
      .meip_i      ( meip_i[h]              ),
      .seip_i      ( seip_i[h]              ),
      .rdata_o     ( slice_rdata[h]         ),
      .irq_valid_o ( irq_valid_o[h]         ),
      .irq_id_o    ( irq_id_o[h]            )
    );
  end

  reg_rsp_mux #(
    .NUM_HARTS     ( NUM_HARTS )
  ) i_reg_rsp_mux (
    .rsp_sel_i     ( rsp_sel         ),
    .rsp_valid_i   ( rsp_valid       ),
    .slice_rdata_i ( slice_rdata     ),
    .rsp_valid_o   ( reg_rsp_valid_o ),
    .rdata_o       ( reg_rdata_o     ),
    .rsp_err_o     ( reg_rsp_err_o   )
  );

  // ------------------------------------------------------------------------
  // debug requests
  // ------------------------------------------------------------------------
  debug_req_gate #(
    .NUM_HARTS      ( NUM_HARTS  ),
    .DEL_CYCLES     ( DEL_CYCLES )
  ) i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

//--- verification/tb_clk_gen.sv
/*
 * Testbench clock and reset source.
 * Free running clock and an active low reset held for RST_CYCLES cycles.
 */

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // reset drops on a falling edge, away from the sampling edge
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- verification/tb_irq_subsystem.sv
/*
 * Testbench for the interrupt subsystem.
 * Drives the register bus, interrupt levels and debug requests on falling
 * edges, keeps a model of each hart's enable and software-pending state,
 * checks the DUT with immediate assertions and ends with an error report.
 */

`timescale 1ns/100ps

module tb_irq_subsystem;

  import clic_pkg::*;

  localparam int NUM_HARTS     = 4;
  localparam int DEL_CYCLES    = 20;
  localparam int CLK_PERIOD_NS = 40;
  localparam int RST_CYCLES    = 5;
  localparam int N_GATE        = 16;
  localparam int N_ENA_ROUNDS  = 2;
  localparam int N_IRQ         = 40;

  // cycle budget per section, a bus access takes two cycles
  localparam int EST_CYCLES = RST_CYCLES + DEL_CYCLES + 2 + N_GATE
                            + N_ENA_ROUNDS * NUM_HARTS * (NUM_HARTS + 1) * 2
                            + (6 + 2 * NUM_HARTS) * 2
                            + N_IRQ * (2 * NUM_HARTS + 6)
                            + NUM_HARTS * 20;
  localparam int WATCHDOG_NS = (2 * EST_CYCLES + 100) * CLK_PERIOD_NS;

  logic                    clk;
  logic                    rst_n;
  logic                    reg_req;
  logic                    reg_we;
  reg_addr_t               reg_addr;
  reg_data_t               reg_wdata;
  logic                    reg_rsp_valid;
  reg_data_t               reg_rdata;
  logic                    reg_rsp_err;
  logic [NUM_HARTS-1:0]    timer_irq;
  logic [NUM_HARTS-1:0]    meip;
  logic [NUM_HARTS-1:0]    seip;
  logic [NUM_HARTS-1:0]    irq_valid;
  src_id_t [NUM_HARTS-1:0] irq_id;
  logic                    debug_enable;
  logic [NUM_HARTS-1:0]    debug_req;
  logic [NUM_HARTS-1:0]    debug_req_o;

  // model state
  src_vec_t                en_m [NUM_HARTS];
  logic                    sw_m [NUM_HARTS];
  logic [31:0]             seed_q;
  int                      mismatch_cnt;
  int                      fault_cnt;

  tb_clk_gen #(
    .PERIOD_NS  ( CLK_PERIOD_NS ),
    .RST_CYCLES ( RST_CYCLES    )
  ) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  irq_subsystem_top #(
    .NUM_HARTS  ( NUM_HARTS  ),
    .DEL_CYCLES ( DEL_CYCLES )
  ) dut_i (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .reg_req_i       ( reg_req       ),
    .reg_we_i        ( reg_we        ),
    .reg_addr_i      ( reg_addr      ),
    .reg_wdata_i     ( reg_wdata     ),
    .reg_rsp_valid_o ( reg_rsp_valid ),
    .reg_rdata_o     ( reg_rdata     ),
    .reg_rsp_err_o   ( reg_rsp_err   ),
    .timer_irq_i     ( timer_irq     ),
    .meip_i          ( meip          ),
    .seip_i          ( seip          ),
    .irq_valid_o     ( irq_valid     ),
    .irq_id_o        ( irq_id        ),
    .debug_enable_i  ( debug_enable  ),
    .debug_req_i     ( debug_req     ),
    .debug_req_o     ( debug_req_o   )
  );

  // --------------------------------------------------------------------------
  // random numbers and reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed_q = xorshift32(seed_q);
    return seed_q;
  endfunction

  function automatic reg_addr_t hart_addr(input int h, input reg_addr_t off);
    return CLIC_BASE + reg_addr_t'(h) * HART_STRIDE + off;
  endfunction

  // source vector as the slice should see it
  function automatic src_vec_t pend_vec(input int h);
    src_vec_t v;
    v = '0;
    v[SRC_MSIP] = sw_m[h];
    v[SRC_MTIP] = timer_irq[h];
    v[SRC_SEIP] = seip[h];
    v[SRC_MEIP] = meip[h];
    return v;
  endfunction

  // scan down from the top, first set bit wins
  function automatic src_id_t top_index(input src_vec_t v);
    src_id_t id;
    logic    found;
    id    = '0;
    found = 1'b0;
    for (int i = int'(NUM_SRC) - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        id    = src_id_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  function automatic reg_data_t claim_word(input int h);
    src_vec_t act;
    act = pend_vec(h) & en_m[h];
    return {(act != '0), 27'd0, top_index(act)};
  endfunction

  // --------------------------------------------------------------------------
  // checks and bus access
  // --------------------------------------------------------------------------
  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatch_cnt++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_irqs(input string name);
    src_vec_t act;
    string    tag;
    for (int h = 0; h < NUM_HARTS; h++) begin
      act = pend_vec(h) & en_m[h];
      tag = $sformatf("%s hart %0d", name, h);
      check_eq({tag, " valid"}, 32'(act != '0), 32'(irq_valid[h]));
      if (act != '0) begin
        check_eq({tag, " id"}, 32'(top_index(act)), 32'(irq_id[h]));
      end
    end
  endtask

  // one request cycle, response sampled on the next falling edge
  task automatic bus_access(input string name, input logic we, input reg_addr_t addr,
                            input reg_data_t wdata, output reg_data_t rdata,
                            output logic err);
    @(negedge clk);
    assert (reg_rsp_valid === 1'b0) else begin
      fault_cnt++;
      $display("%s: response valid high without a request", name);
    end
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    @(negedge clk);
    reg_req = 1'b0;
    reg_we  = 1'b0;
    assert (reg_rsp_valid === 1'b1) else begin
      fault_cnt++;
      $display("%s: no response one cycle after the request", name);
    end
    rdata = reg_rdata;
    err   = reg_rsp_err;
  endtask

  task automatic write_reg(input string name, input int h, input reg_addr_t off,
                           input reg_data_t data);
    reg_data_t rd;
    logic      er;
    string     tag;
    tag = $sformatf("%s hart %0d", name, h);
    bus_access(tag, 1'b1, hart_addr(h, off), data, rd, er);
    check_eq({tag, " wr data"}, 32'h0, rd);
    check_eq({tag, " wr err"}, 32'h0, 32'(er));
    if (off == OFF_ENABLE) begin
      en_m[h] = data[NUM_SRC-1:0];
    end
    if (off == OFF_SWPEND) begin
      sw_m[h] = data[0];
    end
  endtask

  task automatic read_check(input string name, input int h, input reg_addr_t off,
                            input reg_data_t exp);
    reg_data_t rd;
    logic      er;
    string     tag;
    tag = $sformatf("%s hart %0d", name, h);
    bus_access(tag, 1'b0, hart_addr(h, off), '0, rd, er);
    check_eq(tag, exp, rd);
    check_eq({tag, " err"}, 32'h0, 32'(er));
  endtask

  task automatic err_check(input string name, input logic we, input reg_addr_t addr);
    reg_data_t rd;
    logic      er;
    bus_access(name, we, addr, next_rand(), rd, er);
    check_eq({name, " data"}, ERR_VAL, rd);
    check_eq({name, " err"}, 32'h1, 32'(er));
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0]          r;
    logic [NUM_HARTS-1:0] exp_dbg;
    int                   hs;
    reg_req      = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    timer_irq    = '0;
    meip         = '0;
    seip         = '0;
    debug_enable = 1'b1;
    debug_req    = '1;
    seed_q       = 32'ha92fcf72;
    mismatch_cnt = 0;
    fault_cnt    = 0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      en_m[h] = '0;
      sw_m[h] = 1'b0;
    end

    // reset state and debug hold-off
    wait (rst_n === 1'b1);
    check_eq("reset rsp_valid", 32'h0, 32'(reg_rsp_valid));
    check_eq("reset irq_valid", 32'h0, 32'(irq_valid));
    for (int n = 0; n < DEL_CYCLES; n++) begin
      check_eq($sformatf("debug hold cycle %0d", n), 32'h0, 32'(debug_req_o));
      @(negedge clk);
    end
    check_eq("debug open", 32'(debug_req), 32'(debug_req_o));

    // gate follows requests only while enabled
    for (int n = 0; n < N_GATE; n++) begin
      r            = next_rand();
      debug_enable = (n % 3 != 2);
      debug_req    = r[NUM_HARTS-1:0];
      exp_dbg      = debug_enable ? debug_req : '0;
      @(negedge clk);
      check_eq($sformatf("debug gate %0d", n), 32'(exp_dbg), 32'(debug_req_o));
    end

    // --------------------------------------------------------------------------
    // enable registers, one write then read back of every hart
    // --------------------------------------------------------------------------
    for (int k = 0; k < N_ENA_ROUNDS; k++) begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        write_reg("enable_wr", h, OFF_ENABLE, next_rand());
        for (int g = 0; g < NUM_HARTS; g++) begin
          read_check("enable_rd", g, OFF_ENABLE, reg_data_t'(en_m[g]));
        end
      end
    end

    // outside every window, then unknown offsets inside
    err_check("err below base", 1'b0, CLIC_BASE - 32'h4);
    err_check("err low memory", 1'b0, 32'h0000_1000);
    err_check("err at end", 1'b0, CLIC_BASE + reg_addr_t'(NUM_HARTS) * HART_STRIDE);
    err_check("err past end", 1'b0,
              CLIC_BASE + reg_addr_t'(NUM_HARTS) * HART_STRIDE + 32'h100);
    err_check("err top", 1'b0, 32'hFFFF_FFFC);
    err_check("err write", 1'b1, CLIC_BASE - 32'h10);
    for (int h = 0; h < NUM_HARTS; h++) begin
      read_check("unknown off 0x10", h, 32'h10, 32'h0);
      read_check("unknown off top", h, HART_STRIDE - 32'h4, 32'h0);
    end

    // --------------------------------------------------------------------------
    // random interrupt levels and enables
    // --------------------------------------------------------------------------
    for (int n = 0; n < N_IRQ; n++) begin
      r = next_rand();
      if (r[0]) begin
        for (int h = 0; h < NUM_HARTS; h++) begin
          write_reg("irq_en", h, OFF_ENABLE, next_rand());
        end
      end
      @(negedge clk);
      timer_irq = r[4 +: NUM_HARTS];
      meip      = r[8 +: NUM_HARTS];
      seip      = r[12 +: NUM_HARTS];
      @(negedge clk);
      check_irqs($sformatf("irq_sel %0d", n));
      hs = n % NUM_HARTS;
      read_check("irq_pending", hs, OFF_PENDING, reg_data_t'(pend_vec(hs)));
      read_check("irq_claim", hs, OFF_CLAIM, claim_word(hs));
    end

    // software interrupt against the timer source
    @(negedge clk);
    timer_irq = '0;
    meip      = '0;
    seip      = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      write_reg("sw_en", h, OFF_ENABLE, 32'h0000_0888);
      write_reg("sw_set", h, OFF_SWPEND, 32'h1);
      check_irqs("sw_set");
      read_check("sw_rd_set", h, OFF_SWPEND, 32'h1);
      @(negedge clk);
      timer_irq[h] = 1'b1;
      @(negedge clk);
      check_irqs("sw_higher_timer");
      write_reg("sw_en_low", h, OFF_ENABLE, 32'h0000_0008);
      check_irqs("sw_alone");
      write_reg("sw_clr", h, OFF_SWPEND, 32'h0);
      check_irqs("sw_clr");
      read_check("sw_rd_clr", h, OFF_SWPEND, 32'h0);
      @(negedge clk);
      timer_irq[h] = 1'b0;
    end

    @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
rtl/clic_pkg.sv
rtl/reg_addr_demux.sv
rtl/hart_irq_ctrl.sv
rtl/reg_rsp_mux.sv
rtl/debug_req_gate.sv
rtl/irq_subsystem_top.sv
verification/tb_clk_gen.sv
verification/tb_irq_subsystem.sv

//--- Makefile
# Verilator flow for the interrupt subsystem
# Any variable below can be overridden on the command line,
# for example: make sim LOG=run1.log

VERILATOR   ?= verilator
FILELIST    ?= verilog.f
TOP         ?= tb_irq_subsystem
LINT_TOP    ?= irq_subsystem_top
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
PASS_STRING ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

# static checks on the RTL top level
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

# build the testbench, run it and look for the pass line in the log
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_STRING)$$" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
